/* sf_core.f */
sf_num_pkg.sv
sf_isa_pkg.sv
sf_read_stage.sv
sf_arith_stage.sv
sf_scale_stage.sv
sf_port_stage.sv
sf_core.sv
tb_clock_gen.sv
sf_core_checker.sv
sf_core_tb.sv

/* Makefile */
SRCS := $(shell cat sf_core.f)

.PHONY: run clean

obj_dir/Vsf_core_tb: sf_core.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module sf_core_tb -f sf_core.f -o Vsf_core_tb

run: obj_dir/Vsf_core_tb
	./obj_dir/Vsf_core_tb | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* sf_core_tb.sv */
// simulation top that feeds seeded random instructions to the core against a random sink ready
`timescale 1ns/1ns

module sf_core_tb;
	import sf_num_pkg::*;
	import sf_isa_pkg::*;

	// instruction count of each test
	localparam int N_INSTR = 52 + 78 + 292 + 24 + 12;
	// 40 cycles per instruction and 100 of slack
	localparam int LIMIT = 40 * N_INSTR + 100;

	logic       clk;
	logic       arst_n;
	inst_t      inst;
	logic       inst_valid;
	logic       inst_ready;
	port_word_t meas;
	port_t      port;
	logic       port_valid;
	logic       port_ready;
	logic       sat;
	logic       collide;
	int         err_cnt;
	int         chk_cnt;
	logic       idle;
	logic       bp_mode;
	int         seed;
	int         cycles;
	int         n_tests;
	int         err_base;
	int         chk_base;

	tb_clock_gen u_clk (.clk_o(clk), .arst_n_o(arst_n));

	sf_core uut (
		.clk(clk), .arst_n_i(arst_n), .inst_i(inst), .inst_valid_i(inst_valid),
		.inst_ready_o(inst_ready), .meas_i(meas), .port_o(port), .port_valid_o(port_valid),
		.port_ready_i(port_ready), .sat_o(sat), .collide_o(collide)
	);

	sf_core_checker u_chk (
		.clk(clk), .arst_n_i(arst_n), .inst_i(inst), .inst_valid_i(inst_valid),
		.inst_ready_i(inst_ready), .meas_i(meas), .port_i(port), .port_valid_i(port_valid),
		.port_ready_i(port_ready), .sat_i(sat), .collide_i(collide),
		.err_cnt_o(err_cnt), .chk_cnt_o(chk_cnt), .idle_o(idle)
	);

	function automatic inst_t mk(input logic set, input logic [1:0] sv, input op_e op,
		input logic [4:0] wa, input logic [4:0] rb, input logic [4:0] ra);
		inst_t i;
		i.set = set;
		i.sv = sv;
		i.op = op;
		i.wa = wa;
		i.rb = rb;
		i.ra = ra;
		return i;
	endfunction

	// hold valid until the core takes it
	task automatic issue(input inst_t i, input port_word_t m);
		inst <= i;
		meas <= m;
		inst_valid <= 1'b1;
		@(posedge clk);
		while (!inst_ready) @(posedge clk);
		inst_valid <= 1'b0;
	endtask

	task automatic pad(input int n);
		repeat (n) issue(mk(1'b0, 2'd0, OP_NOP, 5'd0, 5'd0, 5'd0), '0);
	endtask

	// alu op and four spacers before its result goes out through a port
	task automatic alu_case(input op_e op, input logic [1:0] sv,
		input logic [4:0] ra, input logic [4:0] rb, input logic [4:0] wa);
		issue(mk(1'b0, sv, op, wa, rb, ra), '0);
		pad(4);
		issue(mk(1'b0, 2'd0, OP_PORT_AB, 5'd0, wa, wa), '0);
	endtask

	task automatic finish_test(input string name);
		do @(negedge clk); while (!idle);
		// next stimulus starts on a rising edge
		@(posedge clk);
		n_tests++;
		$display("test %0d %s: %0d checks, %0d errors", n_tests, name,
			chk_cnt - chk_base, err_cnt - err_base);
		err_base = err_cnt;
		chk_base = chk_cnt;
	endtask

	always @(posedge clk) begin
		if (bp_mode) port_ready <= ($random(seed) & 1) != 0;
		else port_ready <= 1'b1;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout, run passed %0d cycles without finishing", LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial begin
		logic [31:0] r;
		logic [8:0]  v;
		port_word_t  m;
		logic [31:0] bp_r [24];
		seed = 86;
		cycles = 0;
		n_tests = 0;
		err_base = 0;
		chk_base = 0;
		bp_mode = 1'b0;
		inst = '0;
		meas = '0;
		inst_valid = 1'b0;
		port_ready = 1'b1;
		@(posedge arst_n);
		@(posedge clk);

		// load every register and read them back in pairs
		for (int k = 0; k < 32; k++)
			issue(mk(1'b1, 2'd0, OP_NOP, 5'(k), 5'd0, 5'd0), port_word_t'($random(seed)));
		pad(4);
		for (int k = 0; k < 16; k++)
			issue(mk(1'b0, 2'd0, k[0] ? OP_PORT_CD : OP_PORT_AB, 5'd0, 5'(2*k+1), 5'(2*k)), '0);
		finish_test("load and read-out");

		// large equal operands force the sum past the register range
		issue(mk(1'b1, 2'd0, OP_NOP, 5'd14, 5'd0, 5'd0), 18'h1ffff);
		issue(mk(1'b1, 2'd0, OP_NOP, 5'd15, 5'd0, 5'd0), 18'h1ffff);
		pad(4);
		alu_case(OP_ADD, 2'd3, 5'd14, 5'd15, 5'd16);
		alu_case(OP_ADD, 2'd2, 5'd14, 5'd14, 5'd17);
		for (int k = 0; k < 10; k++) begin
			r = $random(seed);
			alu_case(r[0] ? OP_SUB : OP_ADD, r[2:1], {1'b0, r[6:3]}, {1'b0, r[10:7]},
				{1'b1, r[14:11]});
		end
		finish_test("add and subtract");

		for (int k = 0; k < 12; k++) begin
			r = $random(seed);
			alu_case(r[0] ? OP_INV : OP_MUL, r[2:1], {1'b0, r[6:3]}, {1'b0, r[10:7]},
				{1'b1, r[14:11]});
		end
		// every leading-one position and zero in both signs
		for (int neg = 0; neg < 2; neg++) begin
			for (int k = -1; k < 9; k++) begin
				r = $random(seed);
				v = (k < 0) ? 9'd0 : 9'((1 << k) | (r[8:0] & ((1 << k) - 1)));
				m = neg ? {1'b1, ~v, r[16:9]} : {1'b0, v, r[16:9]};
				issue(mk(1'b1, 2'd0, OP_NOP, 5'd20, 5'd0, 5'd0), m);
				pad(4);
				alu_case(OP_INV, r[18:17], 5'd20, 5'd20, 5'd21);
			end
		end
		finish_test("multiply and inverse");

		// sink ready at random and instructions with random gaps
		for (int k = 0; k < 24; k++)
			bp_r[k] = $random(seed);
		bp_mode <= 1'b1;
		for (int k = 0; k < 24; k++) begin
			repeat (bp_r[k][1:0]) @(posedge clk);
			issue(mk(1'b0, 2'd0, bp_r[k][2] ? OP_PORT_CD : OP_PORT_AB, 5'd0,
				bp_r[k][12:8], bp_r[k][7:3]), '0);
		end
		bp_mode <= 1'b0;
		finish_test("back-pressure");

		// target starts at the negative limit and the alu result would be the positive one
		issue(mk(1'b1, 2'd0, OP_NOP, 5'd16, 5'd0, 5'd0), 18'h20000);
		// set lands on the same edge as the alu writeback
		issue(mk(1'b0, 2'd3, OP_ADD, 5'd16, 5'd15, 5'd14), '0);
		pad(4);
		issue(mk(1'b1, 2'd0, OP_NOP, 5'd17, 5'd0, 5'd0), port_word_t'($random(seed)));
		pad(4);
		issue(mk(1'b0, 2'd0, OP_PORT_AB, 5'd0, 5'd17, 5'd16), '0);
		finish_test("collision");

		$display("tests %0d, checks %0d, errors %0d", n_tests, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* sf_core_checker.sv */
// testbench checker, runs a reference model of the pipeline and compares port words and flags
`timescale 1ns/1ns

module sf_core_checker (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  sf_isa_pkg::inst_t      inst_i,
	input  logic                   inst_valid_i,
	input  logic                   inst_ready_i,
	input  sf_num_pkg::port_word_t meas_i,
	input  sf_isa_pkg::port_t      port_i,
	input  logic                   port_valid_i,
	input  logic                   port_ready_i,
	input  logic                   sat_i,
	input  logic                   collide_i,
	output int                     err_cnt_o,
	output int                     chk_cnt_o,
	output logic                   idle_o
);
	import sf_num_pkg::*;
	import sf_isa_pkg::*;

	// alu result waiting for its register write
	typedef struct packed {
		logic [31:0] due;
		reg_addr_t   wa;
		reg_word_t   data;
		logic        sat;
	} pend_t;

	reg_word_t rf [32];
	port_t     exp_port [$];
	pend_t     pend [$];
	int        adv_cnt;

	// unscaled operate result, from the arithmetic rules
	function automatic longint operate(input op_e op, input reg_word_t a, input reg_word_t b);
		longint           la;
		longint           lb;
		logic [8:0]       idx;
		logic [9:0]       mag;
		logic             neg;
		int               p;
		logic signed [WW-1:0] w;
		la = longint'(a);
		lb = longint'(b);
		case (op)
			// top 18-bit slices, keep the top bits of the product
			OP_MUL: return ((la >>> 4) * (lb >>> 4)) >>> 10;
			OP_ADD: return (la + lb) * 4;
			OP_SUB: return (la - lb) * 4;
			default: begin
				neg = a[DW-1];
				idx = neg ? ~a[DW-2:DW-10] : a[DW-2:DW-10];
				p = -1;
				for (int k = 8; k >= 0; k--) begin
					if (p < 0 && idx[k]) p = 8 - k;
				end
				if (p < 0) mag = 10'd1023;
				else if (p == 8) mag = 10'd512;
				else if (idx[7-p]) mag = 10'(1 << (p + 1));
				else mag = 10'(3 << p);
				w = {neg, (neg ? ~mag : mag), {15{neg}}};
				return longint'(w);
			end
		endcase
	endfunction

	// shift by 3 - sv, clip to the 22-bit signed range
	task automatic scale(input longint r, input logic [1:0] sv,
		output reg_word_t data, output logic sat);
		longint v;
		v = r >>> (3 - sv);
		sat = (v >= (64'sd1 <<< 21)) || (v < -(64'sd1 <<< 21));
		if (!sat) data = reg_word_t'(v);
		else if (v > 0) data = {1'b0, {21{1'b1}}};
		else data = {1'b1, {21{1'b0}}};
	endtask

	task automatic fail(input string msg);
		err_cnt_o++;
		$display("FAIL %0t: %s", $time, msg);
	endtask

	initial begin
		err_cnt_o = 0;
		chk_cnt_o = 0;
	end

	// sampled at the edge, before the testbench drives new inputs
	always @(posedge clk or negedge arst_n_i) begin
		pend_t     e;
		port_t     pw;
		logic      due;
		logic      set_now;
		logic      exp_sat;
		reg_word_t d;
		logic      s;
		if (!arst_n_i) begin
			exp_port.delete();
			pend.delete();
			adv_cnt = 0;
			idle_o = 1'b1;
		end else begin
			if (port_valid_i && port_ready_i) begin
				chk_cnt_o++;
				if (exp_port.size() == 0) begin
					err_cnt_o++;
					$display("port write at %0t that no instruction asked for", $time);
				end else begin
					pw = exp_port.pop_front();
					if (port_i !== pw)
						fail($sformatf("port word %h expected %h", port_i, pw));
				end
			end
			if (inst_ready_i) begin
				adv_cnt++;
				due = (pend.size() > 0) && (pend[0].due == adv_cnt);
				set_now = inst_valid_i && inst_i.set;
				exp_sat = due ? pend[0].sat : 1'b0;
				chk_cnt_o += 2;
				if (sat_i !== exp_sat)
					fail($sformatf("sat_o %b expected %b", sat_i, exp_sat));
				if (collide_i !== (due && set_now))
					fail($sformatf("collide_o %b expected %b", collide_i, due && set_now));
				// set wins, the alu write is dropped
				if (due) begin
					e = pend.pop_front();
					if (!set_now) rf[e.wa] = e.data;
				end
				if (set_now) rf[inst_i.wa] = {meas_i, 4'b0000};
				if (inst_valid_i) begin
					case (inst_i.op)
						OP_PORT_AB, OP_PORT_CD: begin
							pw.sel = (inst_i.op == OP_PORT_CD);
							pw.first = rf[inst_i.ra][DW-1:4];
							pw.second = rf[inst_i.rb][DW-1:4];
							exp_port.push_back(pw);
						end
						OP_MUL, OP_INV, OP_ADD, OP_SUB: begin
							scale(operate(inst_i.op, rf[inst_i.ra], rf[inst_i.rb]), inst_i.sv, d, s);
							e.due = adv_cnt + 5;
							e.wa = inst_i.wa;
							e.data = d;
							e.sat = s;
							pend.push_back(e);
						end
						default: ;
					endcase
				end
			end
			idle_o = (exp_port.size() == 0) && (pend.size() == 0);
		end
	end

endmodule

/* tb_clock_gen.sv */
// testbench clock of 10 ns period and an active-low reset held for the first 3 cycles
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk_o,
	output logic arst_n_o
);
	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;
	end

	initial begin
		arst_n_o = 1'b0;
		repeat (3) @(posedge clk_o);
		arst_n_o <= 1'b1;
	end

endmodule

/* sf_core.sv */
// top level of the fixed-point pipeline, stages joined under one back-pressure advance
`timescale 1ns/1ns

module sf_core (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  sf_isa_pkg::inst_t      inst_i,
	input  logic                   inst_valid_i,
	output logic                   inst_ready_o,
	input  sf_num_pkg::port_word_t meas_i,
	output sf_isa_pkg::port_t      port_o,
	output logic                   port_valid_o,
	input  logic                   port_ready_i,
	output logic                   sat_o,
	output logic                   collide_o
);
	import sf_isa_pkg::*;

	// edges after acceptance at t
	//   t    set write
	//   t+1  operands
	//   t+2  alu result, port capture
	//   t+3  shift
	//   t+4  saturate, sat_o
	//   t+5  register write
	logic      advance;
	rd_stage_t rd;
	ar_stage_t ar;
	wb_t       wb;

	// only a port word the sink refuses holds the pipeline
	assign advance      = ~(port_valid_o & ~port_ready_i);
	assign inst_ready_o = advance;

	sf_read_stage u_read (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.advance_i    (advance),
		.inst_i       (inst_i),
		.inst_valid_i (inst_valid_i),
		.meas_i       (meas_i),
		.wb_i         (wb),
		.rd_o         (rd),
		.collide_o    (collide_o)
	);

	sf_arith_stage u_arith (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.advance_i (advance),
		.rd_i      (rd),
		.ar_o      (ar)
	);

	// writeback loops back into the read stage
	sf_scale_stage u_scale (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.advance_i (advance),
		.ar_i      (ar),
		.wb_o      (wb),
		.sat_o     (sat_o)
	);

	sf_port_stage u_port (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.advance_i    (advance),
		.rd_i         (rd),
		.port_o       (port_o),
		.port_valid_o (port_valid_o),
		.port_ready_i (port_ready_i)
	);

endmodule

/* sf_port_stage.sv */
// port stage, captures port-write operands and holds them until the sink takes them
`timescale 1ns/1ns

module sf_port_stage (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  advance_i,
	input  sf_isa_pkg::rd_stage_t rd_i,
	output sf_isa_pkg::port_t     port_o,
	output logic                  port_valid_o,
	input  logic                  port_ready_i
);
	import sf_num_pkg::*;
	import sf_isa_pkg::*;

	logic  is_port;
	port_t port_q;
	logic  port_vld_q;

	assign is_port = rd_i.valid && (rd_i.op == OP_PORT_AB || rd_i.op == OP_PORT_CD);

	// a held word stalls the core, so capture only ever follows acceptance
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			port_vld_q <= 1'b0;
		end else if (advance_i && is_port) begin
			port_vld_q <= 1'b1;
		end else if (port_ready_i) begin
			port_vld_q <= 1'b0;
		end
	end

	// guard bits dropped on the way out
	always_ff @(posedge clk) begin
		if (advance_i && is_port) begin
			port_q.sel    <= (rd_i.op == OP_PORT_CD);
			port_q.first  <= rd_i.a[DW-1:EXTRA];
			port_q.second <= rd_i.b[DW-1:EXTRA];
		end
	end

	assign port_o       = port_q;
	assign port_valid_o = port_vld_q;

	// held word and its valid stay put until taken
	a_port_hold: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		port_valid_o && !port_ready_i |=> port_valid_o && $stable(port_o)
	) else $error("port word changed while waiting for the sink");

endmodule

/* sf_scale_stage.sv */
// scale stage, arithmetic shift by the sv field then saturate to register width with a flag
`timescale 1ns/1ns

module sf_scale_stage (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  advance_i,
	input  sf_isa_pkg::ar_stage_t ar_i,
	output sf_isa_pkg::wb_t       wb_o,
	output logic                  sat_o
);
	import sf_num_pkg::*;
	import sf_isa_pkg::*;

	// shift register stage
	wide_word_t shifted;
	sc_stage_t  sc_d;
	sc_stage_t  sc_q;
	logic       sc_vld_q;
	// saturate register stage
	logic       top_agree;
	reg_word_t  sat_val;
	wb_t        wb_d;
	wb_t        wb_q;
	logic       wb_vld_q;
	logic       sat_q;

	// sv 3 keeps the value, sv 0 divides by 8
	assign shifted = $signed(ar_i.result) >>> (2'd3 - ar_i.sv);

	always_comb begin
		sc_d.valid = ar_i.valid;
		sc_d.wa    = ar_i.wa;
		sc_d.value = shifted;
	end

	// top five bits all sign means the low DW bits hold the value
	assign top_agree = (&sc_q.value[WW-1:DW-1]) | ~(|sc_q.value[WW-1:DW-1]);
	// clip to the largest magnitude of matching sign
	assign sat_val   = top_agree ? sc_q.value[DW-1:0]
		: {sc_q.value[WW-1], {(DW-1){~sc_q.value[WW-1]}}};

	always_comb begin
		wb_d.valid = sc_vld_q;
		wb_d.wa    = sc_q.wa;
		wb_d.data  = sat_val;
		wb_d.sat   = sc_vld_q & ~top_agree;
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sc_vld_q <= 1'b0;
			wb_vld_q <= 1'b0;
			sat_q    <= 1'b0;
		end else if (advance_i) begin
			sc_vld_q <= sc_d.valid;
			wb_vld_q <= wb_d.valid;
			sat_q    <= wb_d.sat;
		end
	end

	always_ff @(posedge clk) begin
		if (advance_i) begin
			sc_q <= sc_d;
			wb_q <= wb_d;
		end
	end

	always_comb begin
		wb_o       = wb_q;
		wb_o.valid = wb_vld_q;
		wb_o.sat   = sat_q;
	end
	assign sat_o = sat_q;

	// a flag without a write would be a lost result
	a_sat_has_write: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		sat_o |-> wb_o.valid
	) else $error("saturation flagged without a writeback");

endmodule

/* sf_arith_stage.sv */
// operate stage, multiply, add/subtract and coarse inverse with a registered result select
`timescale 1ns/1ns

module sf_arith_stage (
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  advance_i,
	input  sf_isa_pkg::rd_stage_t rd_i,
	output sf_isa_pkg::ar_stage_t ar_o
);
	import sf_num_pkg::*;
	import sf_isa_pkg::*;

	// table of 2^(p+1) or 3*2^p, p the leading-one position from the msb
	function automatic logic [ISCALE:0] inv_mag(input logic [ISCALE-1:0] idx);
		logic [ISCALE:0] ext;
		logic [ISCALE:0] mag;
		// trailing one makes index 1 come out as 512
		ext = {idx, 1'b1};
		// zero index gets the largest code, 1023
		mag = '1;
		// ascending scan so the leading one is the last hit
		for (int i = 0; i < ISCALE; i++) begin
			if (idx[i]) begin
				mag = '0;
				mag[ISCALE-i] = 1'b1;
				mag[ISCALE-1-i] = ~ext[i];
			end
		end
		return mag;
	endfunction

	// multiplier slices
	logic signed [MW-1:0]   mul_a;
	logic signed [MW-1:0]   mul_b;
	logic signed [2*MW-1:0] product;
	// one extra bit for the sum
	logic signed [DW:0]     sum;
	logic                   inv_neg;
	logic [ISCALE-1:0]      inv_idx;
	logic [ISCALE:0]        inv_abs;
	wide_word_t             r_mul;
	wide_word_t             r_add;
	wide_word_t             r_inv;
	ar_stage_t              ar_d;
	ar_stage_t              ar_q;
	logic                   ar_vld_q;

	// a*b/2, top bits of the full product
	assign mul_a   = rd_i.a[DW-1:DW-MW];
	assign mul_b   = rd_i.b[DW-1:DW-MW];
	assign product = mul_a * mul_b;
	assign r_mul   = product[2*MW-1:2*MW-WW];

	// (a +/- b)/2
	assign sum   = (rd_i.op == OP_SUB) ? ($signed(rd_i.a) - $signed(rd_i.b))
		: ($signed(rd_i.a) + $signed(rd_i.b));
	assign r_add = {sum[DW], sum, 2'b00};

	// ones complement gives the magnitude index of a negative value
	assign inv_neg = rd_i.a[DW-1];
	assign inv_idx = inv_neg ? ~rd_i.a[DW-2:DW-1-ISCALE] : rd_i.a[DW-2:DW-1-ISCALE];
	assign inv_abs = inv_mag(inv_idx);
	assign r_inv   = {inv_neg, (inv_neg ? ~inv_abs : inv_abs), {(WW-ISCALE-2){inv_neg}}};

	always_comb begin
		// port ops and nops stop here
		ar_d.valid = rd_i.valid && (rd_i.op inside {OP_MUL, OP_INV, OP_ADD, OP_SUB});
		ar_d.sv    = rd_i.sv;
		ar_d.wa    = rd_i.wa;
		case (rd_i.op)
			OP_MUL:  ar_d.result = r_mul;
			OP_INV:  ar_d.result = r_inv;
			default: ar_d.result = r_add;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ar_vld_q <= 1'b0;
		end else if (advance_i) begin
			ar_vld_q <= ar_d.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance_i) begin
			ar_q <= ar_d;
		end
	end

	always_comb begin
		ar_o       = ar_q;
		ar_o.valid = ar_vld_q;
	end

endmodule

/* sf_read_stage.sv */
// register file with measurement and writeback writes and two registered operand reads
`timescale 1ns/1ns

module sf_read_stage (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic                   advance_i,
	input  sf_isa_pkg::inst_t      inst_i,
	input  logic                   inst_valid_i,
	input  sf_num_pkg::port_word_t meas_i,
	input  sf_isa_pkg::wb_t        wb_i,
	output sf_isa_pkg::rd_stage_t  rd_o,
	output logic                   collide_o
);
	import sf_num_pkg::*;
	import sf_isa_pkg::*;

	// accepted instruction, held one cycle to address the file
	inst_t     inst_q;
	logic      inst_vld_q;
	// one array, read twice
	reg_word_t rf [NREG];
	logic      set_we;
	logic      wb_we;
	logic      rf_we;
	reg_addr_t rf_wa;
	reg_word_t rf_wd;
	// operand record
	rd_stage_t rd_d;
	rd_stage_t rd_q;
	logic      rd_vld_q;

	// measurement lands on the accepting edge itself
	assign set_we = advance_i & inst_valid_i & inst_i.set;
	assign wb_we  = advance_i & wb_i.valid;
	assign rf_we  = set_we | wb_we;
	// set beats a same-cycle alu writeback
	assign rf_wa  = set_we ? inst_i.wa : wb_i.wa;
	// guard bits of a measurement start at zero
	assign rf_wd  = set_we ? reg_word_t'({meas_i, {EXTRA{1'b0}}}) : wb_i.data;
	assign collide_o = set_we & wb_we;

	always_ff @(posedge clk) begin
		if (rf_we) begin
			rf[rf_wa] <= rf_wd;
		end
	end

	// no forwarding, a write this edge is seen one edge later
	always_comb begin
		rd_d.valid = inst_vld_q;
		rd_d.op    = inst_q.op;
		rd_d.sv    = inst_q.sv;
		rd_d.wa    = inst_q.wa;
		rd_d.a     = rf[inst_q.ra];
		rd_d.b     = rf[inst_q.rb];
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			inst_vld_q <= 1'b0;
			rd_vld_q   <= 1'b0;
		end else if (advance_i) begin
			// bubble when nothing is accepted
			inst_vld_q <= inst_valid_i;
			rd_vld_q   <= rd_d.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance_i) begin
			inst_q <= inst_i;
			rd_q   <= rd_d;
		end
	end

	always_comb begin
		rd_o       = rd_q;
		rd_o.valid = rd_vld_q;
	end

	// stalled pipeline must not inject new work
	a_no_rise_on_stall: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		!advance_i |=> !$rose(rd_o.valid)
	) else $error("operand valid rose while stalled");

endmodule

/* sf_isa_pkg.sv */
// instruction format, opcodes and the stage-to-stage records of the pipeline
package sf_isa_pkg;

	import sf_num_pkg::*;

	// 32 registers
	localparam int RA_W = 5;
	localparam int NREG = 1 << RA_W;

	typedef logic [RA_W-1:0] reg_addr_t;

	// opcode 3 is unused and runs as a nop
	typedef enum logic [2:0] {
		OP_NOP     = 3'd0,
		OP_PORT_AB = 3'd1,
		OP_PORT_CD = 3'd2,
		OP_MUL     = 3'd4,
		OP_INV     = 3'd5,
		OP_ADD     = 3'd6,
		OP_SUB     = 3'd7
	} op_e;

	// 21-bit instruction word, set in the msb
	typedef struct packed {
		logic       set;
		logic [1:0] sv;
		op_e        op;
		reg_addr_t  wa;
		reg_addr_t  rb;
		reg_addr_t  ra;
	} inst_t;

	// operands out of the register file
	typedef struct packed {
		logic      valid;
		op_e       op;
		logic [1:0] sv;
		reg_addr_t wa;
		reg_word_t a;
		reg_word_t b;
	} rd_stage_t;

	// selected alu result, before scaling
	typedef struct packed {
		logic       valid;
		logic [1:0] sv;
		reg_addr_t  wa;
		wide_word_t result;
	} ar_stage_t;

	// shifted, not yet saturated
	typedef struct packed {
		logic       valid;
		reg_addr_t  wa;
		wide_word_t value;
	} sc_stage_t;

	// writeback into the register file
	typedef struct packed {
		logic      valid;
		reg_addr_t wa;
		reg_word_t data;
		logic      sat;
	} wb_t;

	// pair written to the outside sink
	// sel 0 for ab, 1 for cd
	typedef struct packed {
		logic       sel;
		port_word_t first;
		port_word_t second;
	} port_t;

endpackage

/* sf_num_pkg.sv */
// fixed-point widths and word types, imported by every stage of the arithmetic pipeline
package sf_num_pkg;

	// port values as the radio side sees them
	localparam int PW = 18;
	// guard bits, carried in registers but not on ports
	localparam int EXTRA = 4;
	localparam int DW = PW + EXTRA;

	// multiplier inputs come from the msbs of each operand
	localparam int MW = 18;

	// non-sign bits that index the coarse inverse table
	localparam int ISCALE = 9;

	// operate stage output
	// 4 bits of headroom over a register, trimmed by scale and saturate
	localparam int WW = DW + 4;

	// value as written to or read from a port
	typedef logic signed [PW-1:0] port_word_t;

	// register file entry
	typedef logic signed [DW-1:0] reg_word_t;

	// unscaled result of mul, add/sub or inverse
	typedef logic signed [WW-1:0] wide_word_t;

endpackage
